// ==== src/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Fetch address after reset or after halt is released
`define RESET_VECTOR  32'h0000_0100

// Throw vector table base, low five bits must stay clear
`define VECTOR_ADDR   32'h0000_0040

`define TRAMP_BOTTOM  32'h0000_0080 // Trap handler entry
`define TRAP_ADDR     32'h0000_0020 // Return address slot in data memory

// Register numbers, the top one is the program counter
`define NUM_REGS      16

`endif

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic signed [31:0] word_t;
    typedef logic [3:0] regIdx_t;

    // Where the immediate lands among A, B and C
    typedef enum logic [1:0] {
        kindImmC  = 2'd0, // A=X, B=Y, C=imm
        kindImmB  = 2'd1, // A=X, B=imm, C=Y
        kindImmA  = 2'd2, // A=imm, B=X, C=Y
        kindThrow = 2'd3
    } insnKind_e;

    typedef enum logic [3:0] {
        opOr, opAnd, opAdd, opMul,
        opRsvd, opShl, opLt, opEq,
        opGe, opAndn, opXor, opSub,
        opXnor, opShr, opNe, opSar
    } aluOp_e;

    // Instruction word, top bit first
    typedef struct packed {
        insnKind_e   kind;
        logic        storing;
        logic        derefRhs; // Result is used as an address
        regIdx_t     z;
        regIdx_t     x;
        regIdx_t     y;
        aluOp_e      op;
        logic [11:0] imm;
    } insn_t;

    typedef struct packed {
        word_t a;
        word_t b;
        word_t c;
    } operands_t;

    // Data memory request, no handshake
    typedef struct packed {
        logic  strobe;
        logic  rw;     // High for a write
        word_t addr;
        word_t wdata;
    } dataReq_t;

endpackage

// ==== src/registerFile.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module registerFile import cpu_pkg::*; (
    input  logic    clk,
    input  logic    upZ,
    input  regIdx_t idxZ,
    input  regIdx_t idxX,
    input  regIdx_t idxY,
    input  word_t   nextZ,
    input  word_t   nextP,
    output word_t   valZ,
    output word_t   valX,
    output word_t   valY
);

    localparam regIdx_t pIdx = regIdx_t'(`NUM_REGS - 1); // Program counter alias

    // Register 0 is hardwired, only r1 up to r14 hold state
    word_t store [1:`NUM_REGS-2];

    logic writable;

    assign writable = (idxZ != '0) && (idxZ != pIdx);

    // Zero and P are decoded ahead of the array
    assign valX = (idxX == '0) ? '0 : (idxX == pIdx) ? nextP : store[idxX];
    assign valY = (idxY == '0) ? '0 : (idxY == pIdx) ? nextP : store[idxY];
    assign valZ = (idxZ == '0) ? '0 : (idxZ == pIdx) ? nextP : store[idxZ];

    always_ff @(posedge clk) begin
        if (upZ && writable) begin
            store[idxZ] <= nextZ;
        end
    end

endmodule

// ==== src/insnDecoder.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module insnDecoder import cpu_pkg::*; (
    input  insn_t      insn,
    output insn_t      fields,
    output logic       isThrow,
    output logic       isBranch,
    output logic [4:0] vector
);

    localparam regIdx_t pIdx = regIdx_t'(`NUM_REGS - 1);

    always_comb begin
        fields   = insn;
        isThrow  = (insn.kind == kindThrow);

        // Writing P redirects the fetch, a store leaves P alone
        isBranch = (insn.z == pIdx) && !insn.storing;

        vector   = insn.imm[4:0]; // Index into the vector table
    end

endmodule

// ==== src/operandShuffler.sv ====
`timescale 1ns/1ps

module operandShuffler import cpu_pkg::*; (
    input  logic        clk,
    input  logic        en,
    input  insnKind_e   kind,
    input  word_t       x,
    input  word_t       y,
    input  logic [11:0] imm,
    output operands_t   ops
);

    word_t immExt;

    assign immExt = {{20{imm[11]}}, imm}; // Sign extend

    always_ff @(posedge clk) begin
        if (en) begin
            case (kind)
                kindImmB: begin
                    ops <= '{a: x, b: immExt, c: y};
                end
                kindImmA: begin
                    ops <= '{a: immExt, b: x, c: y};
                end
                default: begin
                    // kindImmC, and a throw which never reaches the ALU
                    ops <= '{a: x, b: y, c: immExt};
                end
            endcase
        end
    end

endmodule

// ==== src/aluExec.sv ====
`timescale 1ns/1ps

module aluExec import cpu_pkg::*; (
    input  logic      clk,
    input  logic      en,
    input  aluOp_e    op,
    input  operands_t ops,
    output word_t     result
);

    word_t fab; // f(a, b) before C is added

    // Comparisons give all ones when true
    always_comb begin
        case (op)
            opOr:    fab = ops.a | ops.b;
            opAnd:   fab = ops.a & ops.b;
            opAdd:   fab = ops.a + ops.b;
            opMul:   fab = ops.a * ops.b;     // Low 32 bits
            opShl:   fab = ops.a << ops.b;
            opLt:    fab = {32{ops.a < ops.b}};
            opEq:    fab = {32{ops.a == ops.b}};
            opGe:    fab = {32{ops.a >= ops.b}};
            opAndn:  fab = ops.a & ~ops.b;
            opXor:   fab = ops.a ^ ops.b;
            opSub:   fab = ops.a - ops.b;
            opXnor:  fab = ops.a ~^ ops.b;
            opShr:   fab = ops.a >> ops.b;    // Logical
            opNe:    fab = {32{ops.a != ops.b}};
            opSar:   fab = ops.a >>> ops.b;   // Arithmetic, a is signed
            default: fab = '0;                // opRsvd
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            result <= fab + ops.c;
        end
    end

endmodule

// ==== src/cpuCore.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpuCore import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     halt,
    input  logic     trap,
    output word_t    iAddr,
    input  word_t    iData,
    output dataReq_t dReq,
    input  word_t    dIn
);

    typedef enum logic [3:0] {
        sI, s0, s1, s2, s3, s4, s5, s6, s7, // Idle and the normal sequence
        sE, sF, sR, sT, sW                  // Throw and trap flow
    } state_e;

    state_e     state;
    insn_t      insn;     // Instruction register
    insn_t      fields;
    logic       isThrow;
    logic       isBranch;
    logic [4:0] vector;

    word_t      valX, valY, valZ;
    operands_t  ops;
    word_t      aluResult;
    word_t      result;   // Latched result, also holds exception addresses
    word_t      loadData;
    word_t      nextP;
    word_t      vAddr;    // Target of a trap or throw
    word_t      nextZ;
    logic       upZ;
    logic       isLoad;

    assign isLoad = fields.derefRhs && !fields.storing;
    assign nextZ  = fields.derefRhs ? loadData : result;
    assign upZ    = (state == s5) && !fields.storing;

    // Sequencer
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= sI;
        end else begin
            case (state)
                sI: state <= halt ? sI : s6;
                s0: begin
                    if (halt)         state <= sI;
                    else if (trap)    state <= sF;
                    else if (isThrow) state <= sE;
                    else              state <= s1;
                end
                s1: state <= s2;
                s2: state <= s3;
                s3: state <= s4; // Slack for the multiplier
                s4: state <= s5;
                s5: state <= s6;
                s6: state <= s7;
                s7: state <= s0;
                sE: state <= sR;
                sR: state <= sT;
                sF: state <= sT;
                sT: state <= sW;
                sW: state <= s6;
                default: state <= sI;
            endcase
        end
    end

    // Datapath registers follow the state
    always_ff @(posedge clk) begin
        case (state)
            sI: if (!halt) iAddr <= `RESET_VECTOR;
            s2: result   <= aluResult;
            s4: loadData <= dIn;
            s5: iAddr    <= isBranch ? nextZ : nextP;
            s6: nextP    <= iAddr + 32'sd1;
            s7: insn     <= iData;
            sE: result   <= `VECTOR_ADDR | {27'd0, vector};
            sR: vAddr    <= dIn;              // Vector table entry
            sF: vAddr    <= `TRAMP_BOTTOM;
            sT: result   <= iAddr;            // Return address to save
            sW: iAddr    <= vAddr;
            default: ;
        endcase
    end

    // Data bus: normal access in s4, vector read in sR, return address save in sW
    always_comb begin
        dReq.strobe = ((state == s4) && (isLoad || fields.storing))
                      || (state == sR) || (state == sW);
        dReq.rw     = ((state == s4) && fields.storing) || (state == sW);
        case (state)
            sW: begin
                dReq.addr  = `TRAP_ADDR;
                dReq.wdata = result;
            end
            sR: begin
                dReq.addr  = result;
                dReq.wdata = valZ;
            end
            default: begin
                // derefRhs stores z at the result, otherwise the result at z
                dReq.addr  = fields.derefRhs ? result : valZ;
                dReq.wdata = fields.derefRhs ? valZ : result;
            end
        endcase
    end

    insnDecoder u_decoder (
        .insn     (insn),
        .fields   (fields),
        .isThrow  (isThrow),
        .isBranch (isBranch),
        .vector   (vector)
    );

    registerFile u_regs (
        .clk   (clk),
        .upZ   (upZ),
        .idxZ  (fields.z),
        .idxX  (fields.x),
        .idxY  (fields.y),
        .nextZ (nextZ),
        .nextP (nextP),
        .valZ  (valZ),
        .valX  (valX),
        .valY  (valY)
    );

    operandShuffler u_shuffler (
        .clk  (clk),
        .en   (state == s0),
        .kind (fields.kind),
        .x    (valX),
        .y    (valY),
        .imm  (fields.imm),
        .ops  (ops)
    );

    aluExec u_alu (
        .clk    (clk),
        .en     (state == s1),
        .op     (fields.op),
        .ops    (ops),
        .result (aluResult)
    );

endmodule

// ==== tests/cpuCore_sva.sv ====
`timescale 1ns/1ps

module cpuCore_sva import cpu_pkg::*; (
    input logic  clk,
    input logic  reset_n,
    input logic  strobe,
    input logic  memSlot,  // Normal load/store cycle
    input insn_t insn,
    input word_t wdata
);

    // The cycle after a reset edge the sequencer sits idle
    resetQuiet: assert property (@(posedge clk) !reset_n |=> !strobe)
        else $error("data strobe high during reset");

    strobePulse: assert property (@(posedge clk) disable iff (!reset_n)
        strobe |=> !strobe)
        else $error("data strobe held longer than one cycle");

    // A store of r0 puts zero on the bus whatever was written to r0 before
    zeroStore: assert property (@(posedge clk) disable iff (!reset_n)
        (memSlot && strobe && insn.storing && insn.derefRhs && (insn.z == '0))
        |-> (wdata == '0))
        else $error("store of register 0 put a nonzero word on the bus");

endmodule

bind cpuCore cpuCore_sva u_sva (
    .clk     (clk),
    .reset_n (reset_n),
    .strobe  (dReq.strobe),
    .memSlot (state == s4),
    .insn    (fields),
    .wdata   (dReq.wdata)
);

// ==== tests/cpuCore_tb.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpuCore_tb import cpu_pkg::*; ;

    localparam int numPrograms = 22;
    localparam int maxInsns    = 8;
    localparam realtime watchdogTime = numPrograms * maxInsns * 12 * 40;

    logic clk = 1'b0;
    logic reset_n = 1'b0;
    logic halt = 1'b0;
    logic trap = 1'b0;
    word_t iAddr, iData, dIn;
    dataReq_t dReq;

    word_t imem [0:511];
    word_t dmem [0:511];
    dataReq_t storeQ [$]; // Writes seen on the bus
    word_t fetchQ [$];    // iAddr at each write
    int strobeCount;
    int errors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    integer seed = 32'he8ab;

    always #20 clk = ~clk;

    assign iData = imem[iAddr[8:0]];
    assign dIn   = dmem[dReq.addr[8:0]];

    cpuCore u_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .halt    (halt),
        .trap    (trap),
        .iAddr   (iAddr),
        .iData   (iData),
        .dReq    (dReq),
        .dIn     (dIn)
    );

    always @(posedge clk) begin
        if (dReq.strobe === 1'b1) begin
            strobeCount++;
            if (dReq.rw) begin
                dmem[dReq.addr[8:0]] <= dReq.wdata;
                storeQ.push_back(dReq);
                fetchQ.push_back(iAddr);
            end
        end
    end

    function automatic insn_t mkInsn(insnKind_e k, logic st, logic dr, regIdx_t z,
                                     regIdx_t x, regIdx_t y, aluOp_e op, logic [11:0] imm);
        return '{k, st, dr, z, x, y, op, imm};
    endfunction

    function automatic word_t sext(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // Reference ALU, comparisons give minus one when true
    function automatic word_t refAlu(aluOp_e op, word_t a, word_t b);
        case (op)
            opOr:   return a | b;
            opAnd:  return a & b;
            opAdd:  return a + b;
            opMul:  return a * b;
            opShl:  return a << $unsigned(b);
            opLt:   return (a < b) ? -32'sd1 : 32'sd0;
            opEq:   return (a == b) ? -32'sd1 : 32'sd0;
            opGe:   return (a >= b) ? -32'sd1 : 32'sd0;
            opAndn: return a & ~b;
            opXor:  return a ^ b;
            opSub:  return a - b;
            opXnor: return ~(a ^ b);
            opShr:  return $unsigned(a) >> $unsigned(b);
            opNe:   return (a != b) ? -32'sd1 : 32'sd0;
            opSar:  return a >>> $unsigned(b);
            default: return 32'sd0;
        endcase
    endfunction

    task automatic checkWord(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic checkReq(string name, dataReq_t exp, dataReq_t act);
        if (act !== exp) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Holds reset and refills both memories
    task automatic beginTest();
        @(negedge clk);
        reset_n = 1'b0;
        for (int i = 0; i < 512; i++) begin
            imem[i] = mkInsn(kindImmC, 0, 0, 0, 0, 0, opOr, 12'(i ^ (i >> 3)));
            dmem[i] = i * 32'h9e37_79b9;
        end
    endtask

    task automatic releaseCore();
        repeat (3) @(negedge clk);
        storeQ.delete();
        fetchQ.delete();
        strobeCount = 0;
        reset_n = 1'b1;
    endtask

    task automatic put(int idx, insn_t insn);
        imem[`RESET_VECTOR + idx] = insn;
    endtask

    task automatic waitStores(string name, int n);
        int cycles;
        cycles = 0;
        while (storeQ.size() < n && cycles < 300) begin
            @(negedge clk);
            cycles++;
        end
        if (storeQ.size() < n) begin
            $display("%s: the core never issued store number %0d", name, n);
            errors++;
        end
    endtask

    task automatic finishTest(string name, int errBefore);
        testsRun++;
        if (errors > errBefore) begin
            testsFailed++;
            $display("%s: %0d mismatches", name, errors - errBefore);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic testAlu();
        int e0;
        word_t a, b, bEff;
        logic [11:0] imm;
        regIdx_t yReg;
        e0 = errors;
        for (int k = 0; k < 16; k++) begin
            a = $random(seed);
            b = $random(seed);
            imm = $random(seed);
            // Shifts take a small amount from r3
            yReg = (aluOp_e'(k) inside {opShl, opShr, opSar}) ? 4'd3 : 4'd2;
            bEff = (yReg == 4'd3) ? (b & 32'sd31) : b;
            beginTest();
            dmem[1] = a;
            dmem[2] = b;
            dmem[3] = b & 32'sd31;
            put(0, mkInsn(kindImmC, 0, 1, 1, 0, 0, opOr, 12'd1));
            put(1, mkInsn(kindImmC, 0, 1, 2, 0, 0, opOr, 12'd2));
            put(2, mkInsn(kindImmC, 0, 1, 3, 0, 0, opOr, 12'd3));
            put(3, mkInsn(kindImmC, 1, 0, 0, 1, yReg, aluOp_e'(k), imm));
            releaseCore();
            waitStores("aluFunctions", 1);
            if (storeQ.size() >= 1)
                checkReq($sformatf("aluFunctions op %0d", k),
                         '{1'b1, 1'b1, 32'sd0, refAlu(aluOp_e'(k), a, bEff) + sext(imm)},
                         storeQ[0]);
        end
        finishTest("aluFunctions", e0);
    endtask

    task automatic testPlacement();
        int e0;
        word_t a, b;
        e0 = errors;
        a = $random(seed);
        b = $random(seed);
        beginTest();
        dmem[1] = a;
        dmem[2] = b;
        put(0, mkInsn(kindImmC, 0, 1, 1, 0, 0, opOr, 12'd1));
        put(1, mkInsn(kindImmC, 0, 1, 2, 0, 0, opOr, 12'd2));
        put(2, mkInsn(kindImmB, 1, 0, 0, 1, 2, opSub, 12'h9ab));
        put(3, mkInsn(kindImmA, 1, 0, 0, 1, 2, opSub, 12'h9ab));
        releaseCore();
        waitStores("immPlacement", 2);
        if (storeQ.size() >= 2) begin
            checkWord("immPlacement B", a - sext(12'h9ab) + b, storeQ[0].wdata);
            checkWord("immPlacement A", sext(12'h9ab) - a + b, storeQ[1].wdata);
        end
        finishTest("immPlacement", e0);
    endtask

    task automatic testLoadZero();
        int e0;
        word_t v;
        e0 = errors;
        v = $random(seed);
        beginTest();
        dmem[5] = v;
        put(0, mkInsn(kindImmC, 0, 1, 1, 0, 0, opOr, 12'd5));
        put(1, mkInsn(kindImmC, 1, 1, 1, 0, 0, opOr, 12'h030)); // Echo r1 to 0x30
        put(2, mkInsn(kindImmC, 0, 0, 0, 1, 0, opOr, 12'd0));   // Try to write r0
        put(3, mkInsn(kindImmC, 1, 1, 0, 0, 0, opOr, 12'h031));
        releaseCore();
        waitStores("loadAndZero", 2);
        if (storeQ.size() >= 2) begin
            checkReq("loadAndZero echo", '{1'b1, 1'b1, 32'sh30, v}, storeQ[0]);
            checkReq("loadAndZero r0", '{1'b1, 1'b1, 32'sh31, 32'sd0}, storeQ[1]);
        end
        finishTest("loadAndZero", e0);
    endtask

    task automatic testBranch();
        int e0;
        e0 = errors;
        beginTest();
        put(0, mkInsn(kindImmC, 0, 0, 15, 0, 0, opOr, 12'h180));
        put(1, mkInsn(kindImmC, 1, 0, 0, 0, 0, opOr, 12'h111)); // Skipped
        imem[9'h180] = mkInsn(kindImmC, 1, 0, 0, 0, 0, opOr, 12'h222);
        releaseCore();
        waitStores("branch", 1);
        if (storeQ.size() >= 1) begin
            checkWord("branch data", 32'sh222, storeQ[0].wdata);
            checkWord("branch fetch", 32'sh180, fetchQ[0]);
        end
        finishTest("branch", e0);
    endtask

    task automatic testTrapThrow();
        int e0;
        e0 = errors;
        // Trap taken at the first s0
        beginTest();
        trap = 1'b1;
        imem[`TRAMP_BOTTOM] = mkInsn(kindImmC, 1, 0, 0, 0, 0, opOr, 12'h333);
        releaseCore();
        waitStores("trap", 1);
        trap = 1'b0;
        waitStores("trap", 2);
        if (storeQ.size() >= 2) begin
            checkReq("trap save", '{1'b1, 1'b1, `TRAP_ADDR, `RESET_VECTOR}, storeQ[0]);
            checkWord("trap fetch", `TRAMP_BOTTOM, fetchQ[1]);
        end
        beginTest();
        dmem[`VECTOR_ADDR | 5] = 32'sh1a0;
        put(0, mkInsn(kindThrow, 0, 0, 0, 0, 0, opOr, 12'd5));
        imem[9'h1a0] = mkInsn(kindImmC, 1, 0, 0, 0, 0, opOr, 12'h444);
        releaseCore();
        waitStores("throw", 2);
        if (storeQ.size() >= 2) begin
            checkReq("throw save", '{1'b1, 1'b1, `TRAP_ADDR, `RESET_VECTOR}, storeQ[0]);
            checkWord("throw fetch", 32'sh1a0, fetchQ[1]);
        end
        finishTest("trapAndThrow", e0);
    endtask

    task automatic testHalt();
        int e0;
        word_t held;
        e0 = errors;
        beginTest();
        halt = 1'b1;
        put(0, mkInsn(kindImmC, 1, 0, 0, 0, 0, opOr, 12'h555));
        releaseCore();
        held = iAddr;
        repeat (40) @(negedge clk);
        if (strobeCount != 0) begin
            $display("halt: data strobe seen while halted");
            errors++;
        end
        checkWord("halt iAddr", held, iAddr);
        halt = 1'b0;
        waitStores("halt", 1);
        if (storeQ.size() >= 1)
            checkWord("halt resume", `RESET_VECTOR, fetchQ[0]);
        finishTest("halt", e0);
    endtask

    initial begin
        #(watchdogTime * 1ns);
        $display("Run timed out before the tests finished");
        $display("Test failures found");
        $finish;
    end

    initial begin
        testAlu();
        testPlacement();
        testLoadZero();
        testBranch();
        testTrapThrow();
        testHalt();
        $display("%0d tests run, %0d failed, %0d mismatches", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/cpu_pkg.sv
src/registerFile.sv
src/insnDecoder.sv
src/operandShuffler.sv
src/aluExec.sv
src/cpuCore.sv
tests/cpuCore_sva.sv
tests/cpuCore_tb.sv
